// ==== build.f ====
+incdir+include
hdl/rvPkg.sv
hdl/rvAlu.sv
hdl/rvDecoder.sv
hdl/rvLsu.sv
hdl/rvRegFile.sv
hdl/rvCsrFile.sv
hdl/rvExecStage.sv
hdl/rvCore.sv
test/rvCore_checker.sv
test/rvCore_tb.sv

// ==== hdl/rvAlu.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvAlu (
  input  logic [31:0]  opA,
  input  logic [31:0]  opB,
  input  rvPkg::aluOpE aluOp,
  input  logic         brUn,
  output logic [31:0]  aluOut,
  output logic         brEq,
  output logic         brLt
);

  logic [4:0] shamt;
  logic       ltSigned;
  logic       ltUnsigned;

  assign shamt = opB[4:0];
  assign ltSigned = $signed(opA) < $signed(opB);
  assign ltUnsigned = opA < opB;

  always_comb begin
    case (aluOp)
      rvPkg::ALU_ADD:  aluOut = opA + opB;
      rvPkg::ALU_SUB:  aluOut = opA - opB;
      rvPkg::ALU_SLL:  aluOut = opA << shamt;
      rvPkg::ALU_SLT:  aluOut = {31'b0, ltSigned};
      rvPkg::ALU_SLTU: aluOut = {31'b0, ltUnsigned};
      rvPkg::ALU_XOR:  aluOut = opA ^ opB;
      rvPkg::ALU_SRL:  aluOut = opA >> shamt;
      rvPkg::ALU_SRA:  aluOut = $signed(opA) >>> shamt;
      rvPkg::ALU_OR:   aluOut = opA | opB;
      rvPkg::ALU_AND:  aluOut = opA & opB;
      default:         aluOut = opB;
    endcase
  end

  // branch compare on the same operands
  assign brEq = (opA == opB);
  assign brLt = brUn ? ltUnsigned : ltSigned;

endmodule

`default_nettype wire

// ==== hdl/rvCore.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_cfg.svh"

module rvCore (
  input  logic           clk,
  input  logic           rstN,
  input  logic           instValid,
  input  rvPkg::instWord inst,
  output logic [31:0]    pc,
  output logic           commitValid,
  output rvPkg::commitS  commit
);

  logic [4:0]    rs1;
  logic [4:0]    rs2;
  logic [4:0]    rd;
  logic          regWrite;
  logic [31:0]   wbData;
  logic [31:0]   regData1;
  logic [31:0]   regData2;
  logic          csrEn;
  logic [1:0]    csrOp;
  logic [11:0]   csrId;
  logic [31:0]   csrWData;
  logic          ecall;
  logic          mret;
  logic [31:0]   csrRData;
  logic [31:0]   mtvec;
  logic [31:0]   mepc;
  logic          memRead;
  logic          memWrite;
  logic [3:0]    wmask;
  rvPkg::memExtE memExt;
  logic [31:0]   memAddr;
  logic [31:0]   memWData;
  logic [31:0]   memRData;
  logic [31:0]   dnpc;
  logic          halt;

  rvExecStage exec_i (
    .instValid(instValid),
    .inst     (inst),
    .pc       (pc),
    .regData1 (regData1),
    .regData2 (regData2),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .regWrite (regWrite),
    .wbData   (wbData),
    .csrEn    (csrEn),
    .csrOp    (csrOp),
    .csrId    (csrId),
    .csrWData (csrWData),
    .ecall    (ecall),
    .mret     (mret),
    .csrRData (csrRData),
    .mtvec    (mtvec),
    .mepc     (mepc),
    .memRead  (memRead),
    .memWrite (memWrite),
    .wmask    (wmask),
    .memExt   (memExt),
    .memAddr  (memAddr),
    .memWData (memWData),
    .memRData (memRData),
    .dnpc     (dnpc),
    .halt     (halt)
  );

  rvRegFile regFile_i (
    .clk   (clk),
    .rstN  (rstN),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .we    (regWrite),
    .wdata (wbData),
    .rdata1(regData1),
    .rdata2(regData2)
  );

  rvCsrFile csrFile_i (
    .clk  (clk),
    .rstN (rstN),
    .csrEn(csrEn),
    .csrOp(csrOp),
    .csrId(csrId),
    .wsrc (csrWData),
    .ecall(ecall),
    .mret (mret),
    .pc   (pc),
    .rdata(csrRData),
    .mtvec(mtvec),
    .mepc (mepc)
  );

  rvLsu lsu_i (
    .clk     (clk),
    .memRead (memRead),
    .memWrite(memWrite),
    .wmask   (wmask),
    .memExt  (memExt),
    .addr    (memAddr),
    .wdata   (memWData),
    .rdata   (memRData)
  );

  // pc only moves on an accepted strobe
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= `RV_RESET_PC;
      commitValid <= 1'b0;
    end else begin
      commitValid <= instValid;
      if (instValid) begin
        pc <= dnpc;
      end
    end
  end

  // retire record, valid the cycle after the strobe
  always_ff @(posedge clk) begin
    if (instValid) begin
      commit.pc <= pc;
      commit.dnpc <= dnpc;
      commit.rd <= rd;
      commit.regWrite <= regWrite;
      commit.wbData <= wbData;
      commit.halt <= halt;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rvCsrFile.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_cfg.svh"

module rvCsrFile (
  input  logic        clk,
  input  logic        rstN,
  input  logic        csrEn,
  input  logic [1:0]  csrOp,
  input  logic [11:0] csrId,
  input  logic [31:0] wsrc,
  input  logic        ecall,
  input  logic        mret,
  input  logic [31:0] pc,
  output logic [31:0] rdata,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);

  localparam logic [11:0] ID_MSTATUS = 12'h300;
  localparam logic [11:0] ID_MTVEC   = 12'h305;
  localparam logic [11:0] ID_MEPC    = 12'h341;
  localparam logic [11:0] ID_MCAUSE  = 12'h342;

  logic [31:0] mstatusQ;
  logic [31:0] mtvecQ;
  logic [31:0] mepcQ;
  logic [31:0] mcauseQ;
  logic [31:0] oldVal;
  logic [31:0] newVal;

  always_comb begin
    case (csrId)
      ID_MSTATUS: oldVal = mstatusQ;
      ID_MTVEC:   oldVal = mtvecQ;
      ID_MEPC:    oldVal = mepcQ;
      ID_MCAUSE:  oldVal = mcauseQ;
      default:    oldVal = '0;
    endcase
  end

  // csrOp is funct3[1:0] of csrrw / csrrs / csrrc
  always_comb begin
    case (csrOp)
      2'b01:   newVal = wsrc;
      2'b10:   newVal = oldVal | wsrc;
      2'b11:   newVal = oldVal & ~wsrc;
      default: newVal = oldVal;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mstatusQ <= '0;
      mtvecQ <= '0;
      mepcQ <= '0;
      mcauseQ <= '0;
    end else if (ecall) begin
      mepcQ <= pc;
      mcauseQ <= `RV_CAUSE_ECALL;
    end else if (csrEn && !mret) begin
      case (csrId)
        ID_MSTATUS: mstatusQ <= newVal;
        ID_MTVEC:   mtvecQ <= newVal;
        ID_MEPC:    mepcQ <= newVal;
        ID_MCAUSE:  mcauseQ <= newVal;
        default: ;
      endcase
    end
  end

  assign rdata = oldVal;
  assign mtvec = mtvecQ;
  assign mepc = mepcQ;

endmodule

`default_nettype wire

// ==== hdl/rvDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvDecoder (
  input  rvPkg::instWord inst,
  output rvPkg::ctrlS    ctrl,
  output logic [31:0]    imm
);

  logic [31:0] iImm;
  logic [31:0] sImm;
  logic [31:0] bImm;
  logic [31:0] uImm;
  logic [31:0] jImm;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        bad;

  function automatic rvPkg::aluOpE aluFromF3(input logic [2:0] fn, input logic alt);
    case (fn)
      3'b000: return alt ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
      3'b001: return rvPkg::ALU_SLL;
      3'b010: return rvPkg::ALU_SLT;
      3'b011: return rvPkg::ALU_SLTU;
      3'b100: return rvPkg::ALU_XOR;
      3'b101: return alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
      3'b110: return rvPkg::ALU_OR;
      default: return rvPkg::ALU_AND;
    endcase
  endfunction

  assign f3 = inst.r.funct3;
  assign f7 = inst.r.funct7;

  // immediates, one per format view
  assign iImm = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign sImm = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
  assign bImm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10to5,
                 inst.b.imm4to1, 1'b0};
  assign uImm = {inst.u.imm, 12'b0};
  assign jImm = {{11{inst.u.imm[19]}}, inst.u.imm[19], inst.u.imm[7:0], inst.u.imm[8],
                 inst.u.imm[18:9], 1'b0};

  always_comb begin
    ctrl = '0;
    imm = '0;
    bad = 1'b0;
    case (inst.r.opcode)
      rvPkg::OP_LUI: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluBSel = rvPkg::B_IMM;
        ctrl.aluOp = rvPkg::ALU_PASSB;
        imm = uImm;
      end
      rvPkg::OP_AUIPC: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluASel = 1'b1;
        ctrl.aluBSel = rvPkg::B_IMM;
        imm = uImm;
      end
      rvPkg::OP_JAL: begin
        ctrl.regWrite = 1'b1;
        ctrl.jump = 1'b1;
        ctrl.aluASel = 1'b1;
        ctrl.aluBSel = rvPkg::B_IMM;
        ctrl.wbSel = rvPkg::WB_SNPC;
        imm = jImm;
      end
      rvPkg::OP_JALR: begin
        ctrl.regWrite = 1'b1;
        ctrl.jalr = 1'b1;
        ctrl.aluBSel = rvPkg::B_IMM;
        ctrl.wbSel = rvPkg::WB_SNPC;
        imm = iImm;
        bad = (f3 != 3'b000);
      end
      rvPkg::OP_BRANCH: begin
        // alu compares rs1 against rs2, target is summed in the exec stage
        ctrl.brType = 1'b1;
        ctrl.brUn = f3[1];
        imm = bImm;
        bad = (f3[2:1] == 2'b01);
      end
      rvPkg::OP_LOAD: begin
        ctrl.regWrite = 1'b1;
        ctrl.memRead = 1'b1;
        ctrl.memExt = rvPkg::memExtE'(f3);
        ctrl.aluBSel = rvPkg::B_IMM;
        ctrl.wbSel = rvPkg::WB_MEM;
        imm = iImm;
        bad = (f3 == 3'b011) || (f3[2:1] == 2'b11);
      end
      rvPkg::OP_STORE: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluBSel = rvPkg::B_IMM;
        imm = sImm;
        case (f3)
          3'b000: ctrl.wmask = 4'b0001;
          3'b001: ctrl.wmask = 4'b0011;
          3'b010: ctrl.wmask = 4'b1111;
          default: bad = 1'b1;
        endcase
      end
      rvPkg::OP_IMM: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluBSel = rvPkg::B_IMM;
        ctrl.aluOp = aluFromF3(f3, (f3 == 3'b101) && f7[5]);
        imm = iImm;
        // shift amounts live in imm[4:0], funct7 must be clean
        if (f3 == 3'b001) begin
          bad = (f7 != 7'b0000000);
        end else if (f3 == 3'b101) begin
          bad = (f7 != 7'b0000000) && (f7 != 7'b0100000);
        end
      end
      rvPkg::OP_REG: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp = aluFromF3(f3, f7[5]);
        bad = (f7 != 7'b0000000) &&
              !((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
      end
      rvPkg::OP_SYSTEM: begin
        if (f3 == 3'b000) begin
          case (inst.i.imm)
            12'h000: ctrl.ecall = 1'b1;
            12'h001: ctrl.ebreak = 1'b1;
            12'h302: ctrl.mret = 1'b1;
            default: bad = 1'b1;
          endcase
        end else if (f3[2] == 1'b0) begin
          // csrrw, csrrs, csrrc; old value goes back through the alu
          ctrl.regWrite = 1'b1;
          ctrl.csrEn = 1'b1;
          ctrl.csrOp = f3[1:0];
          ctrl.aluBSel = rvPkg::B_CSR;
          ctrl.aluOp = rvPkg::ALU_PASSB;
          ctrl.wbSel = rvPkg::WB_CSR;
        end else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase

    // unknown encodings retire as a plain pc+4
    if (bad) begin
      ctrl = '0;
      imm = '0;
      ctrl.illegal = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rvExecStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvExecStage (
  input  logic           instValid,
  input  rvPkg::instWord inst,
  input  logic [31:0]    pc,
  input  logic [31:0]    regData1,
  input  logic [31:0]    regData2,
  output logic [4:0]     rs1,
  output logic [4:0]     rs2,
  output logic [4:0]     rd,
  output logic           regWrite,
  output logic [31:0]    wbData,
  output logic           csrEn,
  output logic [1:0]     csrOp,
  output logic [11:0]    csrId,
  output logic [31:0]    csrWData,
  output logic           ecall,
  output logic           mret,
  input  logic [31:0]    csrRData,
  input  logic [31:0]    mtvec,
  input  logic [31:0]    mepc,
  output logic           memRead,
  output logic           memWrite,
  output logic [3:0]     wmask,
  output rvPkg::memExtE  memExt,
  output logic [31:0]    memAddr,
  output logic [31:0]    memWData,
  input  logic [31:0]    memRData,
  output logic [31:0]    dnpc,
  output logic           halt
);

  rvPkg::ctrlS ctrl;
  logic [31:0] imm;
  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] aluOut;
  logic        brEq;
  logic        brLt;
  logic        brTaken;
  logic [31:0] brTarget;
  logic [31:0] snpc;
  logic        valid;

  rvDecoder decoder_i (
    .inst(inst),
    .ctrl(ctrl),
    .imm (imm)
  );

  assign opA = ctrl.aluASel ? pc : regData1;

  always_comb begin
    case (ctrl.aluBSel)
      rvPkg::B_IMM: opB = imm;
      rvPkg::B_CSR: opB = csrRData;
      default:      opB = regData2;
    endcase
  end

  rvAlu alu_i (
    .opA   (opA),
    .opB   (opB),
    .aluOp (ctrl.aluOp),
    .brUn  (ctrl.brUn),
    .aluOut(aluOut),
    .brEq  (brEq),
    .brLt  (brLt)
  );

  assign rs1 = inst.r.rs1;
  assign rs2 = inst.r.rs2;
  assign rd = inst.r.rd;

  // no side effects without a strobe or for an illegal word
  assign valid = instValid && !ctrl.illegal;
  assign regWrite = valid && ctrl.regWrite;
  assign memRead = valid && ctrl.memRead;
  assign memWrite = valid && ctrl.memWrite;
  assign csrEn = valid && ctrl.csrEn;
  assign ecall = valid && ctrl.ecall;
  assign mret = valid && ctrl.mret;
  assign halt = valid && ctrl.ebreak;

  assign wmask = ctrl.wmask;
  assign memExt = ctrl.memExt;
  assign memAddr = aluOut;
  assign memWData = regData2;
  assign csrOp = ctrl.csrOp;
  assign csrId = inst.i.imm;
  assign csrWData = regData1;

  // funct3[2] picks lt over eq and funct3[0] inverts the result
  assign brTaken = ctrl.brType && ((inst.b.funct3[2] ? brLt : brEq) ^ inst.b.funct3[0]);
  assign brTarget = pc + imm;
  assign snpc = pc + 32'd4;

  always_comb begin
    if (!instValid) begin
      dnpc = pc;
    end else if (ctrl.mret) begin
      dnpc = mepc;
    end else if (ctrl.ecall) begin
      dnpc = mtvec;
    end else if (ctrl.ebreak) begin
      dnpc = pc;
    end else if (brTaken) begin
      dnpc = brTarget;
    end else if (ctrl.jump) begin
      dnpc = aluOut;
    end else if (ctrl.jalr) begin
      dnpc = {aluOut[31:1], 1'b0};
    end else begin
      dnpc = snpc;
    end
  end

  always_comb begin
    case (ctrl.wbSel)
      rvPkg::WB_MEM:  wbData = memRData;
      rvPkg::WB_SNPC: wbData = snpc;
      rvPkg::WB_CSR:  wbData = csrRData;
      default:        wbData = aluOut;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rvLsu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_cfg.svh"

module rvLsu (
  input  logic          clk,
  input  logic          memRead,
  input  logic          memWrite,
  input  logic [3:0]    wmask,
  input  rvPkg::memExtE memExt,
  input  logic [31:0]   addr,
  input  logic [31:0]   wdata,
  output logic [31:0]   rdata
);

  localparam int AW = $clog2(`RV_DMEM_WORDS);

  logic [31:0]   mem [`RV_DMEM_WORDS];
  logic [AW-1:0] idx;
  logic [1:0]    ofs;
  logic [3:0]    laneEn;
  logic [31:0]   laneData;
  logic [31:0]   word;
  logic [31:0]   loadVal;

  // word index, upper address bits wrap around
  assign idx = addr[AW+1:2];
  assign ofs = addr[1:0];

  // move the store mask and data onto the addressed byte lanes
  assign laneEn = wmask << ofs;
  assign laneData = wdata << {ofs, 3'b000};

  always_ff @(posedge clk) begin
    if (memWrite) begin
      for (int b = 0; b < 4; b++) begin
        if (laneEn[b]) begin
          mem[idx][8*b +: 8] <= laneData[8*b +: 8];
        end
      end
    end
  end

  // addressed byte or halfword lands in the low bits
  assign word = mem[idx] >> {ofs, 3'b000};

  always_comb begin
    case (memExt)
      rvPkg::EXT_B:  loadVal = {{24{word[7]}}, word[7:0]};
      rvPkg::EXT_BU: loadVal = {24'b0, word[7:0]};
      rvPkg::EXT_H:  loadVal = {{16{word[15]}}, word[15:0]};
      rvPkg::EXT_HU: loadVal = {16'b0, word[15:0]};
      default:       loadVal = word;
    endcase
  end

  assign rdata = memRead ? loadVal : '0;

endmodule

`default_nettype wire

// ==== hdl/rvPkg.sv ====
`default_nettype none

package rvPkg;

  // base opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeS;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeS;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sTypeS;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } bTypeS;

  // shared by U and J, the J immediate is reshuffled from imm
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } ujTypeS;

  typedef union packed {
    logic [31:0] raw;
    rTypeS       r;
    iTypeS       i;
    sTypeS       s;
    bTypeS       b;
    ujTypeS      u;
  } instWord;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
  } aluOpE;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_SNPC, WB_CSR} wbSelE;

  typedef enum logic [1:0] {B_RS2, B_IMM, B_CSR} opBSelE;

  // values follow funct3 of the load instructions
  typedef enum logic [2:0] {
    EXT_B = 3'b000, EXT_H = 3'b001, EXT_W = 3'b010, EXT_BU = 3'b100, EXT_HU = 3'b101
  } memExtE;

  typedef struct packed {
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic [3:0] wmask;
    memExtE     memExt;
    aluOpE      aluOp;
    logic       aluASel;
    opBSelE     aluBSel;
    // conditional branch, condition comes from funct3
    logic       brType;
    logic       brUn;
    logic       jump;
    logic       jalr;
    logic       csrEn;
    logic [1:0] csrOp;
    logic       ecall;
    logic       mret;
    logic       ebreak;
    wbSelE      wbSel;
    logic       illegal;
  } ctrlS;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] dnpc;
    logic [4:0]  rd;
    logic        regWrite;
    logic [31:0] wbData;
    logic        halt;
  } commitS;

endpackage

`default_nettype wire

// ==== hdl/rvRegFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvRegFile (
  input  logic        clk,
  input  logic        rstN,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else if (we && (rd != 5'd0)) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

// ==== include/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data memory depth in words, power of two
`define RV_DMEM_WORDS 256

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// mcause for an environment call from machine mode
`define RV_CAUSE_ECALL 32'd11

`endif

// ==== test/rvCore_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvCore_checker (
  input logic        clk,
  input logic        rstN,
  input logic        instValid,
  input logic [31:0] pc,
  input logic        commitValid
);

  // read by the testbench at the end of the run
  int failCount = 0;

  // async reset keeps the commit strobe low
  noCommitInReset: assert property (@(posedge clk) !rstN |-> !commitValid)
    else begin
      failCount++;
      $error("commitValid is high while reset is asserted");
    end

  // every accepted strobe retires one cycle later
  commitAfterStrobe: assert property (@(posedge clk) disable iff (!rstN)
    instValid |=> commitValid)
    else begin
      failCount++;
      $error("commitValid did not follow instValid by one cycle");
    end

  singleCommit: assert property (@(posedge clk) disable iff (!rstN)
    commitValid && !instValid |=> !commitValid)
    else begin
      failCount++;
      $error("commitValid stayed high without a second strobe");
    end

  // pc and commitValid update at the same edge
  pcHeld: assert property (@(posedge clk) disable iff (!rstN)
    !commitValid |-> $stable(pc))
    else begin
      failCount++;
      $error("pc changed in a cycle without a commit");
    end

endmodule

`default_nettype wire

// ==== test/rvCore_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_cfg.svh"

module rvCore_tb;

  localparam int COMMIT_TIMEOUT = 20;

  logic           clk;
  logic           rstN;
  logic           instValid;
  rvPkg::instWord inst;
  logic [31:0]    pc;
  logic           commitValid;
  rvPkg::commitS  commit;

  int          errors;
  int          checks;
  int          testsRun;
  int          assertFails;
  int          fd;
  int          fields;
  bit          timedOut;
  logic [31:0] expPc;
  string       line;
  string       testName;
  logic [31:0] word;
  int          expRd;
  int          expRegWrite;
  logic [31:0] expWb;
  logic [31:0] expDnpc;
  int          expHalt;

  rvCore dut_i (
    .clk        (clk),
    .rstN       (rstN),
    .instValid  (instValid),
    .inst       (inst),
    .pc         (pc),
    .commitValid(commitValid),
    .commit     (commit)
  );

  bind rvCore rvCore_checker checker_i (
    .clk        (clk),
    .rstN       (rstN),
    .instValid  (instValid),
    .pc         (pc),
    .commitValid(commitValid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare(input string name, input string field,
                         input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch in %s, %s: expected %h, actual %h", name, field, expected, actual);
    end
  endtask

  // one strobe, then wait for the retire record
  task automatic runTest(input string name, input logic [31:0] instr, input int rd,
                         input int regWrite, input logic [31:0] wb,
                         input logic [31:0] dnpc, input int halt);
    int cycles;
    @(negedge clk);
    compare(name, "pc", expPc, pc);
    inst = instr;
    instValid = 1'b1;
    @(negedge clk);
    instValid = 1'b0;
    inst = '0;
    cycles = 0;
    while (!commitValid && cycles < COMMIT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!commitValid) begin
      errors++;
      timedOut = 1'b1;
      $display("timeout: test %s got no commit within %0d cycles", name, COMMIT_TIMEOUT);
    end else begin
      compare(name, "commit.pc", expPc, commit.pc);
      compare(name, "commit.dnpc", dnpc, commit.dnpc);
      compare(name, "commit.regWrite", 32'(regWrite), 32'(commit.regWrite));
      compare(name, "commit.halt", 32'(halt), 32'(commit.halt));
      // rd and wbData only mean something for a register write
      if (regWrite != 0) begin
        compare(name, "commit.rd", 32'(rd), 32'(commit.rd));
        compare(name, "commit.wbData", wb, commit.wbData);
      end
    end
    expPc = dnpc;
  endtask

  initial begin
    rstN = 1'b0;
    instValid = 1'b0;
    inst = '0;
    errors = 0;
    checks = 0;
    testsRun = 0;
    timedOut = 1'b0;
    expPc = `RV_RESET_PC;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    fd = $fopen("test/rv_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the test file test/rv_tests.txt");
    end else begin
      while (!timedOut && $fgets(line, fd) != 0) begin
        // blank lines and # comments carry no test
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%s %h %d %d %h %h %d", testName, word, expRd,
                           expRegWrite, expWb, expDnpc, expHalt);
          if (fields != 7) begin
            errors++;
            $display("malformed line in the test file: %s", line);
          end else begin
            runTest(testName, word, expRd, expRegWrite, expWb, expDnpc, expHalt);
            testsRun++;
          end
        end
      end
      $fclose(fd);
      if (testsRun == 0) begin
        errors++;
        $display("the test file held no tests");
      end
    end

    assertFails = dut_i.checker_i.failCount;
    errors += assertFails;
    $display("tests run: %0d, checks: %0d, assertion failures: %0d, errors: %0d",
             testsRun, checks, assertFails, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/rv_tests.txt ====
# name inst(hex) rd regWrite(0/1) wbData(hex) dnpc(hex) halt(0/1)
# rd and wbData are checked only when regWrite is 1
addi_pos 00500093 1 1 00000005 80000004 0
addi_neg ffd00113 2 1 fffffffd 80000008 0
add 002081b3 3 1 00000002 8000000c 0
sub 40208233 4 1 00000008 80000010 0
and 0020f2b3 5 1 00000005 80000014 0
or 0020e333 6 1 fffffffd 80000018 0
xor 0020c3b3 7 1 fffffff8 8000001c 0
slt 00112433 8 1 00000001 80000020 0
sltu 001134b3 9 1 00000000 80000024 0
sll 00109533 10 1 000000a0 80000028 0
sra 401155b3 11 1 ffffffff 8000002c 0
srl 00115633 12 1 07ffffff 80000030 0
lui 123456b7 13 1 12345000 80000034 0
auipc 00001717 14 1 80001034 80000038 0
addi_x0 00708013 0 1 0000000c 8000003c 0
add_x0 000007b3 15 1 00000000 80000040 0
beq_taken 00108463 0 0 00000000 80000048 0
beq_not 00208463 0 0 00000000 8000004c 0
blt_taken 00114463 0 0 00000000 80000054 0
bltu_not 00116463 0 0 00000000 80000058 0
bltu_taken 0020e663 0 0 00000000 80000064 0
jal 0100086f 16 1 80000068 80000074 0
jalr 005708e7 17 1 80000078 80001038 0
lui_data 87654937 18 1 87654000 8000103c 0
addi_data 32190913 18 1 87654321 80001040 0
sw 05202023 0 0 00000000 80001044 0
sh 04101123 0 0 00000000 80001048 0
sb 042000a3 0 0 00000000 8000104c 0
lw 04002983 19 1 0005fd21 80001050 0
lh 04001a03 20 1 fffffd21 80001054 0
lhu 04005a83 21 1 0000fd21 80001058 0
lb 04100b03 22 1 fffffffd 8000105c 0
lbu 04104b83 23 1 000000fd 80001060 0
lh_hi 04201c03 24 1 00000005 80001064 0
lui_vec 80002d37 26 1 80002000 80001068 0
csrrw_mtvec 305d1cf3 25 1 00000000 8000106c 0
csrrs_mstatus 3000adf3 27 1 00000000 80001070 0
csrrc_mstatus 30043e73 28 1 00000005 80001074 0
csrr_mstatus 30002ef3 29 1 00000004 80001078 0
csrrw_mcause 34209073 0 1 00000000 8000107c 0
csrr_mcause 34202f73 30 1 00000005 80001080 0
csrr_mtvec 30502f73 30 1 80002000 80001084 0
ecall 00000073 0 0 00000000 80002000 0
trap_mcause 34202ff3 31 1 0000000b 80002004 0
trap_mepc 34102ff3 31 1 80001084 80002008 0
mepc_step 004f8f93 31 1 80001088 8000200c 0
mepc_write 341f9073 0 1 80001084 80002010 0
mret 30200073 0 0 00000000 80001088 0
ebreak 00100073 0 0 00000000 80001088 1
